//--- source/fft8_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame length, sample and result widths,
// twiddle scaling for the 8-point FFT
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FFT8_CONSTS_SVH
`define FFT8_CONSTS_SVH

`define FFT_POINTS 8

// 5 integer bits, 8 fraction bits
`define DATA_W 13
// one growth bit per stage
`define OUT_W 16

`define TWIDDLE_W 8
`define TWIDDLE_SHIFT 6

`define COUNT_W 3

`endif

//--- source/fft8_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sample types, frame states, twiddle table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "fft8_consts.svh"

package fft8_pkg;

  typedef logic signed [`DATA_W-1:0] sample_t;
  typedef logic signed [`OUT_W-1:0] result_t;
  typedef logic signed [`TWIDDLE_W-1:0] twiddle_t;
  typedef logic [`COUNT_W-1:0] index_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    CALC,
    DRAIN
  } frame_state_e;

  // W8^k for k = 0..3, Q6
  localparam twiddle_t twiddle_re [`FFT_POINTS/2] = '{
    twiddle_t'(64),
    twiddle_t'(45),
    twiddle_t'(0),
    twiddle_t'(-45)
  };

  localparam twiddle_t twiddle_im [`FFT_POINTS/2] = '{
    twiddle_t'(0),
    twiddle_t'(-45),
    twiddle_t'(-64),
    twiddle_t'(-45)
  };

endpackage

//--- source/sample_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// position counter within a frame phase
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "fft8_consts.svh"

module sample_counter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  logic              advance,
  output fft8_pkg::index_t  count,
  output logic              last
);
  import fft8_pkg::*;

  // wraps to zero after the last sample of a phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (advance) begin
      count <= count + 1'b1;
    end
  end

  assign last = (count == index_t'(`FFT_POINTS - 1));

endmodule

//--- source/frame_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame FSM for load, compute and drain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module frame_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_in,
  input  logic stage_valid,
  input  logic last,
  output logic ready,
  output logic accept,
  output logic count_clear,
  output logic count_advance,
  output logic write_en,
  output logic read_en
);
  import fft8_pkg::*;

  frame_state_e state_q;
  frame_state_e state_d;
  logic         ready_q;

  // the first sample needs ready and the other seven are taken blindly
  assign accept = ((state_q == IDLE) && ready_q && valid_in) || (state_q == LOAD);

  assign count_clear   = (state_q == IDLE) && !accept;
  assign count_advance = accept || (state_q == DRAIN) || ((state_q == CALC) && stage_valid);
  assign write_en      = (state_q == CALC) && stage_valid;
  assign read_en       = (state_q == DRAIN);

  // stays low through the last registered output
  assign ready = ready_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) state_d = LOAD;
      end
      LOAD: begin
        if (last) state_d = CALC;
      end
      CALC: begin
        if (stage_valid && last) state_d = DRAIN;
      end
      DRAIN: begin
        if (last) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      ready_q <= 1'b1;
    end else begin
      state_q <= state_d;
      ready_q <= (state_q == IDLE) && !accept;
    end
  end

endmodule

//--- source/sdf_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// radix-2 DIF delay-feedback stage with
// butterfly and twiddle rotation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "fft8_consts.svh"

module sdf_stage #(
  parameter int DEPTH = 4,
  parameter int IN_W  = `DATA_W
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   valid_in,
  input  logic signed [IN_W-1:0] in_re,
  input  logic signed [IN_W-1:0] in_im,
  output logic                   valid_out,
  output logic signed [IN_W:0]   out_re,
  output logic signed [IN_W:0]   out_im
);
  import fft8_pkg::*;

  localparam int OUT_W    = IN_W + 1;
  localparam int CNT_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int TW_IDX_W = $clog2(`FFT_POINTS / 2);
  localparam int TW_STEP  = (`FFT_POINTS / 2) / DEPTH;
  localparam int PROD_W   = OUT_W + `TWIDDLE_W;

  typedef enum logic [1:0] {
    FILL,
    BFLY,
    ROT
  } phase_e;

  phase_e                  phase_q;
  phase_e                  phase_d;
  logic [CNT_W-1:0]        k_q;
  logic [CNT_W-1:0]        k_d;
  logic [CNT_W-1:0]        k_next;
  logic                    half_done;
  logic                    in_valid_q;
  logic signed [IN_W-1:0]  in_re_q;
  logic signed [IN_W-1:0]  in_im_q;
  logic signed [OUT_W-1:0] dl_re [DEPTH];
  logic signed [OUT_W-1:0] dl_im [DEPTH];
  logic signed [OUT_W-1:0] a_re;
  logic signed [OUT_W-1:0] a_im;
  logic signed [OUT_W-1:0] b_re;
  logic signed [OUT_W-1:0] b_im;
  logic signed [OUT_W-1:0] push_re;
  logic signed [OUT_W-1:0] push_im;
  logic                    shift_en;
  logic [TW_IDX_W-1:0]     tw_idx;
  twiddle_t                wr;
  twiddle_t                wi;
  logic signed [PROD_W-1:0] prod_re;
  logic signed [PROD_W-1:0] prod_im;
  logic signed [OUT_W-1:0] rot_re;
  logic signed [OUT_W-1:0] rot_im;
  logic                    out_valid_d;
  logic signed [OUT_W-1:0] out_re_d;
  logic signed [OUT_W-1:0] out_im_d;

  // oldest delay entry against the new sample
  assign a_re = dl_re[DEPTH-1];
  assign a_im = dl_im[DEPTH-1];
  assign b_re = OUT_W'(in_re_q);
  assign b_im = OUT_W'(in_im_q);

  assign half_done = (k_q == CNT_W'(DEPTH - 1));
  assign k_next    = half_done ? '0 : k_q + 1'b1;

  // stored difference times W^(k*step)
  assign tw_idx  = TW_IDX_W'(int'(k_q) * TW_STEP);
  assign wr      = twiddle_re[tw_idx];
  assign wi      = twiddle_im[tw_idx];
  assign prod_re = a_re * wr - a_im * wi;
  assign prod_im = a_re * wi + a_im * wr;
  assign rot_re  = OUT_W'(prod_re >>> `TWIDDLE_SHIFT);
  assign rot_im  = OUT_W'(prod_im >>> `TWIDDLE_SHIFT);

  always_comb begin
    phase_d     = phase_q;
    k_d         = k_q;
    shift_en    = 1'b0;
    push_re     = b_re;
    push_im     = b_im;
    out_valid_d = 1'b0;
    out_re_d    = rot_re;
    out_im_d    = rot_im;
    case (phase_q)
      FILL: begin
        if (in_valid_q) begin
          shift_en = 1'b1;
          k_d      = k_next;
          if (half_done) phase_d = BFLY;
        end
      end
      BFLY: begin
        if (in_valid_q) begin
          shift_en    = 1'b1;
          push_re     = a_re - b_re;
          push_im     = a_im - b_im;
          out_valid_d = 1'b1;
          out_re_d    = a_re + b_re;
          out_im_d    = a_im + b_im;
          k_d         = k_next;
          if (half_done) phase_d = ROT;
        end
      end
      ROT: begin
        // a following group may fill while the differences drain
        shift_en    = 1'b1;
        out_valid_d = 1'b1;
        k_d         = k_next;
        if (!in_valid_q) begin
          push_re = '0;
          push_im = '0;
        end
        if (half_done) phase_d = in_valid_q ? BFLY : FILL;
      end
      default: phase_d = FILL;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_valid_q <= 1'b0;
      phase_q    <= FILL;
      k_q        <= '0;
      valid_out  <= 1'b0;
    end else begin
      in_valid_q <= valid_in;
      phase_q    <= phase_d;
      k_q        <= k_d;
      valid_out  <= out_valid_d;
    end
  end

  always_ff @(posedge clk) begin
    in_re_q <= in_re;
    in_im_q <= in_im;
    out_re  <= out_re_d;
    out_im  <= out_im_d;
    if (shift_en) begin
      dl_re[0] <= push_re;
      dl_im[0] <= push_im;
      for (int i = 1; i < DEPTH; i++) begin
        dl_re[i] <= dl_re[i-1];
        dl_im[i] <= dl_im[i-1];
      end
    end
  end

endmodule

//--- source/reorder_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bit-reversed write, natural-order read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "fft8_consts.svh"

module reorder_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              write_en,
  input  logic              read_en,
  input  fft8_pkg::index_t  count,
  input  fft8_pkg::result_t wr_re,
  input  fft8_pkg::result_t wr_im,
  output logic              valid_out,
  output fft8_pkg::result_t rd_re,
  output fft8_pkg::result_t rd_im
);
  import fft8_pkg::*;

  result_t mem_re [`FFT_POINTS];
  result_t mem_im [`FFT_POINTS];
  index_t  wr_addr;

  function automatic index_t bit_rev(input index_t idx);
    index_t rev;
    for (int i = 0; i < `COUNT_W; i++) begin
      rev[i] = idx[`COUNT_W-1-i];
    end
    return rev;
  endfunction

  // stage 3 emits frequency bins in bit-reversed order
  assign wr_addr = bit_rev(count);

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem_re[wr_addr] <= wr_re;
      mem_im[wr_addr] <= wr_im;
    end
    if (read_en) begin
      rd_re <= mem_re[count];
      rd_im <= mem_im[count];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= read_en;
    end
  end

endmodule

//--- source/fft8_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8-point SDF FFT: controller, counter,
// three butterfly stages, output reorder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "fft8_consts.svh"

module fft8_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              valid_in,
  input  fft8_pkg::sample_t data_in_re,
  input  fft8_pkg::sample_t data_in_im,
  output logic              ready,
  output logic              valid_out,
  output fft8_pkg::result_t data_out_re,
  output fft8_pkg::result_t data_out_im
);
  import fft8_pkg::*;

  logic                     accept;
  logic                     count_clear;
  logic                     count_advance;
  logic                     write_en;
  logic                     read_en;
  logic                     last;
  index_t                   count;

  logic                     s1_valid;
  logic signed [`DATA_W:0]  s1_re;
  logic signed [`DATA_W:0]  s1_im;
  logic                     s2_valid;
  logic signed [`DATA_W+1:0] s2_re;
  logic signed [`DATA_W+1:0] s2_im;
  logic                     s3_valid;
  result_t                  s3_re;
  result_t                  s3_im;

  frame_ctrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_in      (valid_in),
    .stage_valid   (s3_valid),
    .last          (last),
    .ready         (ready),
    .accept        (accept),
    .count_clear   (count_clear),
    .count_advance (count_advance),
    .write_en      (write_en),
    .read_en       (read_en)
  );

  sample_counter u_counter (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (count_clear),
    .advance (count_advance),
    .count   (count),
    .last    (last)
  );

  // 13 -> 14 -> 15 -> 16 bits
  sdf_stage #(.DEPTH(4), .IN_W(`DATA_W)) u_stage1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (accept),
    .in_re     (data_in_re),
    .in_im     (data_in_im),
    .valid_out (s1_valid),
    .out_re    (s1_re),
    .out_im    (s1_im)
  );

  sdf_stage #(.DEPTH(2), .IN_W(`DATA_W + 1)) u_stage2 (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (s1_valid),
    .in_re     (s1_re),
    .in_im     (s1_im),
    .valid_out (s2_valid),
    .out_re    (s2_re),
    .out_im    (s2_im)
  );

  sdf_stage #(.DEPTH(1), .IN_W(`DATA_W + 2)) u_stage3 (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (s2_valid),
    .in_re     (s2_re),
    .in_im     (s2_im),
    .valid_out (s3_valid),
    .out_re    (s3_re),
    .out_im    (s3_im)
  );

  reorder_buffer u_reorder (
    .clk       (clk),
    .rst_n     (rst_n),
    .write_en  (write_en),
    .read_en   (read_en),
    .count     (count),
    .wr_re     (s3_re),
    .wr_im     (s3_im),
    .valid_out (valid_out),
    .rd_re     (data_out_re),
    .rd_im     (data_out_im)
  );

endmodule

//--- verification/fft8_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake assertions bound to fft8_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module fft8_sva (
  input logic clk,
  input logic rst_n,
  input logic valid_in,
  input logic ready,
  input logic valid_out
);
  logic [3:0] run_len;
  logic busy;
  int failures = 0;

  // busy from the accepted first sample to the last output cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_len <= '0;
      busy <= 1'b0;
    end else begin
      run_len <= valid_out ? run_len + 1'b1 : 4'd0;
      if (ready && valid_in) begin
        busy <= 1'b1;
      end else if (valid_out && run_len == 4'd7) begin
        busy <= 1'b0;
      end
    end
  end

  rise_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(valid_out) |-> !ready)
    else begin
      $error("valid_out rose while ready was high");
      failures++;
    end

  run_of_eight: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(valid_out) |-> run_len == 4'd8)
    else begin
      $error("valid_out run was not eight cycles");
      failures++;
    end

  idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !valid_out && ready)
    else begin
      $error("outputs not idle after reset");
      failures++;
    end

  ready_low_while_busy: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !ready)
    else begin
      $error("ready high during a frame");
      failures++;
    end

endmodule

bind fft8_top fft8_sva u_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .valid_in  (valid_in),
  .ready     (ready),
  .valid_out (valid_out)
);

//--- verification/fft8_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random frames, DIF reference model,
// result checks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "fft8_consts.svh"

module fft8_tb #(
  parameter int SEED = 24
);
  localparam int CLK_PERIOD = 100;
  localparam int SMALL_FRAMES = 50;
  localparam int LARGE_FRAMES = 20;
  localparam int BUSY_FRAMES = 10;
  localparam int NUM_FRAMES = 2 + SMALL_FRAMES + LARGE_FRAMES + BUSY_FRAMES;
  localparam int FRAME_TIMEOUT = 60;
  // W8^k for k = 0..3 scaled by 64
  localparam int TW_RE [4] = '{64, 45, 0, -45};
  localparam int TW_IM [4] = '{0, -45, -64, -45};

  logic clk;
  logic rst_n;
  logic valid_in;
  logic signed [`DATA_W-1:0] data_in_re;
  logic signed [`DATA_W-1:0] data_in_im;
  logic ready;
  logic valid_out;
  logic signed [`OUT_W-1:0] data_out_re;
  logic signed [`OUT_W-1:0] data_out_im;

  integer seed;
  int checks;
  int errors;
  int tests_run;
  int mark_checks;
  int mark_errors;
  int sva_failures;
  longint const_val;
  longint in_re [8];
  longint in_im [8];
  longint exp_re [8];
  longint exp_im [8];
  longint work_re [8];
  longint work_im [8];
  longint got_re [$];
  longint got_im [$];

  fft8_top uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_in    (valid_in),
    .data_in_re  (data_in_re),
    .data_in_im  (data_in_im),
    .ready       (ready),
    .valid_out   (valid_out),
    .data_out_re (data_out_re),
    .data_out_im (data_out_im)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // outputs are settled mid-cycle
  always @(negedge clk) begin
    if (rst_n && valid_out) begin
      got_re.push_back(longint'(data_out_re));
      got_im.push_back(longint'(data_out_im));
    end
  end

  initial begin
    #(CLK_PERIOD * (NUM_FRAMES * 40 + 100));
    $display("watchdog expired after %0d clock periods", NUM_FRAMES * 40 + 100);
    $display("TEST FAIL");
    $finish;
  end

  function automatic longint wrap_width(input longint value, input int width);
    return (value <<< (64 - width)) >>> (64 - width);
  endfunction

  function automatic int reverse_index(input int idx);
    return ((idx & 1) << 2) | (idx & 2) | ((idx >> 2) & 1);
  endfunction

  // one DIF pass over groups of 2*depth with difference n rotated by W8^(n*4/depth)
  task automatic dif_pass(input int depth, input int width);
    longint d_re;
    longint d_im;
    int lo;
    int hi;
    int k;
    for (int base = 0; base < 8; base += 2 * depth) begin
      for (int n = 0; n < depth; n++) begin
        lo = base + n;
        hi = lo + depth;
        k = n * (4 / depth);
        d_re = wrap_width(work_re[lo] - work_re[hi], width);
        d_im = wrap_width(work_im[lo] - work_im[hi], width);
        work_re[lo] = wrap_width(work_re[lo] + work_re[hi], width);
        work_im[lo] = wrap_width(work_im[lo] + work_im[hi], width);
        work_re[hi] = wrap_width((d_re * TW_RE[k] - d_im * TW_IM[k]) >>> `TWIDDLE_SHIFT, width);
        work_im[hi] = wrap_width((d_re * TW_IM[k] + d_im * TW_RE[k]) >>> `TWIDDLE_SHIFT, width);
      end
    end
  endtask

  task automatic compute_reference();
    work_re = in_re;
    work_im = in_im;
    dif_pass(4, `DATA_W + 1);
    dif_pass(2, `DATA_W + 2);
    dif_pass(1, `DATA_W + 3);
    // bin k ends up at the bit-reversed slot
    for (int k = 0; k < 8; k++) begin
      exp_re[k] = work_re[reverse_index(k)];
      exp_im[k] = work_im[reverse_index(k)];
    end
  endtask

  // mag of 0 means full 13-bit range
  task automatic fill_random_frame(input int mag);
    for (int i = 0; i < 8; i++) begin
      if (mag == 0) begin
        in_re[i] = wrap_width(longint'($random(seed)), `DATA_W);
        in_im[i] = wrap_width(longint'($random(seed)), `DATA_W);
      end else begin
        in_re[i] = longint'($random(seed) % mag);
        in_im[i] = longint'($random(seed) % mag);
      end
    end
    compute_reference();
  endtask

  task automatic check_value(input string what, input longint expected, input longint actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("MISMATCH %s expected %0d actual %0d", what, expected, actual);
    end
  endtask

  task automatic report_test(input string name);
    $display("%-18s checks=%0d errors=%0d", name, checks - mark_checks, errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
    tests_run++;
  endtask

  task automatic run_frame(input string name, input bit noise);
    int waited;
    bit done;
    got_re.delete();
    got_im.delete();
    waited = 0;
    @(negedge clk);
    while (ready !== 1'b1 && waited < FRAME_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    checks++;
    assert (ready === 1'b1) else begin
      errors++;
      $display("%s: ready stayed low and the frame could not start", name);
    end
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      valid_in <= 1'b1;
      data_in_re <= `DATA_W'(in_re[i]);
      data_in_im <= `DATA_W'(in_im[i]);
    end
    waited = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (got_re.size() >= 8 || waited >= FRAME_TIMEOUT) begin
        done = 1'b1;
      end else if (noise && got_re.size() < 6) begin
        // junk the busy DUT has to drop
        valid_in <= ($random(seed) & 3) != 0;
        data_in_re <= `DATA_W'($random(seed));
        data_in_im <= `DATA_W'($random(seed));
      end else begin
        valid_in <= 1'b0;
        data_in_re <= '0;
        data_in_im <= '0;
      end
      waited++;
    end
    checks++;
    assert (got_re.size() == 8) else begin
      errors++;
      $display("%s: only %0d of 8 results arrived in time", name, got_re.size());
    end
    for (int k = 0; k < 8 && k < got_re.size(); k++) begin
      check_value($sformatf("%s X[%0d].re", name, k), exp_re[k], got_re[k]);
      check_value($sformatf("%s X[%0d].im", name, k), exp_im[k], got_im[k]);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    valid_in = 1'b0;
    data_in_re = '0;
    data_in_im = '0;
    seed = SEED;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("idle_after_reset ready", 1, longint'(ready));
    check_value("idle_after_reset valid_out", 0, longint'(valid_out));
    report_test("idle_after_reset");

    for (int i = 0; i < 8; i++) begin
      in_re[i] = (i == 0) ? 100 : 0;
      in_im[i] = 0;
      exp_re[i] = 100;
      exp_im[i] = 0;
    end
    run_frame("impulse", 1'b0);
    report_test("impulse");

    // all energy lands in bin 0
    const_val = wrap_width(longint'($random(seed)), `DATA_W);
    for (int i = 0; i < 8; i++) begin
      in_re[i] = const_val;
      in_im[i] = 0;
      exp_re[i] = (i == 0) ? 8 * const_val : 0;
      exp_im[i] = 0;
    end
    run_frame("constant", 1'b0);
    report_test("constant");

    for (int f = 0; f < SMALL_FRAMES; f++) begin
      fill_random_frame(128);
      run_frame($sformatf("random_small frame %0d", f), 1'b0);
    end
    report_test("random_small");
    for (int f = 0; f < LARGE_FRAMES; f++) begin
      fill_random_frame(0);
      run_frame($sformatf("random_large frame %0d", f), 1'b0);
    end
    report_test("random_large");
    for (int f = 0; f < BUSY_FRAMES; f++) begin
      fill_random_frame(0);
      run_frame($sformatf("ignore_busy frame %0d", f), 1'b1);
    end
    report_test("ignore_busy");

    sva_failures = uut.u_sva.failures;
    if (sva_failures != 0) begin
      $display("bound checker saw %0d assertion failures", sva_failures);
      errors += sva_failures;
    end
    $display("tests=%0d checks=%0d errors=%0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+source
source/fft8_pkg.sv
source/sample_counter.sv
source/frame_ctrl.sv
source/sdf_stage.sv
source/reorder_buffer.sv
source/fft8_top.sv
verification/fft8_sva.sv
verification/fft8_tb.sv

//--- Makefile
TOP       ?= fft8_tb
SEED      ?= 24
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: TOP SEED LOG BUILD_DIR VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) -f flist.f --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
